/* video_pkg.sv */
//--------------------------------------------------------------------
// video timing definitions
// visible area, vertical flip base and line buffer pixel format
//--------------------------------------------------------------------
`default_nettype none

package video_pkg;
    localparam int vis_lines = 224;           // lines 0..223 shown
    localparam logic [8:0] flip_base = 9'd223;

    localparam int line_len = 512;            // buffer positions per line

    // buffer pixel is prio, pal, pixel
    localparam int pxl_w = 12;
endpackage

`default_nettype wire

/* obj_pkg.sv */
//--------------------------------------------------------------------
// object table definitions
// word layout of one 8-word object entry, table size and the
// special graphics nibbles used by the scanner and draw engine
//--------------------------------------------------------------------
`default_nettype none

package obj_pkg;
    localparam int obj_count = 128;
    localparam int obj_words = 8;
    localparam int tbl_depth = obj_count * obj_words;

    // word index inside an entry
    localparam logic [2:0] word_pos     = 3'd0;  // bottom 15:8, top 7:0
    localparam logic [2:0] word_xpos    = 3'd1;
    localparam logic [2:0] word_pitch   = 3'd2;  // signed
    localparam logic [2:0] word_offset  = 3'd3;  // start offset
    localparam logic [2:0] word_attr    = 3'd4;
    localparam logic [2:0] word_scratch = 3'd7;  // running offset

    localparam int xpos_hi      = 8;
    localparam int attr_pal_hi  = 13;
    localparam int attr_pal_lo  = 8;
    localparam int attr_bank_hi = 6;
    localparam int attr_bank_lo = 4;
    localparam int attr_prio_hi = 1;
    localparam int attr_prio_lo = 0;

    localparam logic [7:0] eot_bottom = 8'hf0;  // bottom at/above ends table
    localparam logic [3:0] pix_end    = 4'hf;
    localparam logic [3:0] pix_clear  = 4'h0;   // transparent
    localparam int max_words = 16;              // sprite width cut-off
endpackage

`default_nettype wire

/* obj_table_ram.sv */
//--------------------------------------------------------------------
// object table RAM
// 1024 words, CPU write port plus scanner read/write port,
// scanner write wins on a collision, one cycle read latency
//--------------------------------------------------------------------
`default_nettype none

module obj_table_ram (
    input  wire         clk,
    input  wire  [10:1] cpu_addr,
    input  wire  [15:0] cpu_din,
    input  wire         cpu_we,
    input  wire  [10:1] tbl_addr,
    input  wire  [15:0] tbl_din,
    input  wire         tbl_we,
    output logic [15:0] tbl_dout
);

    logic [15:0] mem [0:obj_pkg::tbl_depth-1];
    logic        cpu_blocked;

    // same word written by both ports
    assign cpu_blocked = tbl_we && (tbl_addr == cpu_addr);

    always_ff @(posedge clk) begin
        if (tbl_we)
            mem[tbl_addr] <= tbl_din;
        if (cpu_we && !cpu_blocked)
            mem[cpu_addr] <= cpu_din;
        tbl_dout <= mem[tbl_addr];  // registered scanner read
    end

endmodule

`default_nettype wire

/* obj_scan.sv */
//--------------------------------------------------------------------
// per-line object scanner
// on hstart walks the object table, picks sprites crossing the
// line, updates their running offset and hands draw commands
// to the draw engine one at a time
//--------------------------------------------------------------------
`default_nettype none

module obj_scan (
    input  wire         clk,
    input  wire         rst,
    input  wire         alt_bank,
    input  wire         hstart,
    input  wire         flip,
    input  wire  [8:0]  vrender,
    output logic [10:1] tbl_addr,
    output logic [15:0] tbl_din,
    output logic        tbl_we,
    input  wire  [15:0] tbl_dout,
    output logic        dr_start,
    input  wire         dr_busy,
    output logic [8:0]  dr_xpos,
    output logic [15:0] dr_offset,
    output logic [3:0]  dr_bank,
    output logic [1:0]  dr_prio,
    output logic [5:0]  dr_pal
);

    typedef enum logic [3:0] {
        st_idle, st_pos, st_zone, st_xpos, st_pitch,
        st_offs, st_attr, st_scr, st_draw
    } state_t;

    state_t      st;
    logic [6:0]  cur_obj;
    logic [2:0]  idx;       // word being addressed
    logic        first;     // object's top line
    logic [8:0]  xpos;
    logic [15:0] pitch;
    logic [15:0] offset;
    logic [2:0]  bank;
    logic [1:0]  prio;
    logic [5:0]  pal;
    logic [3:0]  bank_map;
    logic [8:0]  vrf;
    logic [7:0]  top, bottom;
    logic        in_zone, bad_obj, eot, line_ok, last_obj;

    assign vrf      = flip ? video_pkg::flip_base - vrender : vrender;
    assign line_ok  = vrf < 9'(video_pkg::vis_lines);
    assign top      = tbl_dout[7:0];
    assign bottom   = tbl_dout[15:8];
    assign in_zone  = (vrf[7:0] >= top) && (vrf[7:0] < bottom);
    assign bad_obj  = top >= bottom;
    assign eot      = bottom >= obj_pkg::eot_bottom;
    assign last_obj = cur_obj == 7'(obj_pkg::obj_count - 1);

    assign tbl_addr = {cur_obj, idx};
    assign tbl_din  = offset + pitch;  // next line's offset

    always_comb begin
        if (alt_bank) begin
            case ({1'b0, bank})
                4'd0:    bank_map = 4'd0;
                4'd7:    bank_map = 4'd3;
                4'd11:   bank_map = 4'd2;
                4'd13:   bank_map = 4'd1;
                4'd14:   bank_map = 4'd0;
                default: bank_map = 4'd15;
            endcase
        end else begin
            bank_map = {1'b0, bank};
        end
    end

    // sequencing, read data trails the address by one state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= st_idle;
            cur_obj  <= '0;
            idx      <= '0;
            tbl_we   <= 1'b0;
            dr_start <= 1'b0;
        end else begin
            tbl_we   <= 1'b0;
            dr_start <= 1'b0;
            case (st)
                st_idle: begin
                    if (hstart && line_ok) begin
                        cur_obj <= '0;
                        idx     <= obj_pkg::word_pos;
                        st      <= st_pos;
                    end
                end
                st_pos: begin
                    idx <= obj_pkg::word_xpos;
                    st  <= st_zone;
                end
                st_zone: begin
                    if (eot) begin
                        st <= st_idle;
                    end else if (bad_obj || !in_zone) begin
                        cur_obj <= cur_obj + 7'd1;
                        idx     <= obj_pkg::word_pos;
                        st      <= last_obj ? st_idle : st_pos;
                    end else begin
                        idx <= obj_pkg::word_pitch;
                        st  <= st_xpos;
                    end
                end
                st_xpos: begin
                    idx <= obj_pkg::word_offset;
                    st  <= st_pitch;
                end
                st_pitch: begin
                    idx <= obj_pkg::word_attr;
                    st  <= st_offs;
                end
                st_offs: begin
                    idx <= obj_pkg::word_scratch;
                    st  <= st_attr;
                end
                st_attr: st <= st_scr;
                st_scr: begin
                    tbl_we <= 1'b1;  // scratch write lands in st_draw
                    st     <= st_draw;
                end
                st_draw: begin
                    if (!dr_busy) begin
                        dr_start <= 1'b1;
                        cur_obj  <= cur_obj + 7'd1;
                        idx      <= obj_pkg::word_pos;
                        st       <= last_obj ? st_idle : st_pos;
                    end else if (hstart) begin
                        st <= st_idle;  // line over, give up
                    end
                end
                default: st <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (st)
            st_zone:  first <= top == vrf[7:0];
            st_xpos:  xpos <= tbl_dout[obj_pkg::xpos_hi:0];
            st_pitch: pitch <= tbl_dout;
            st_offs:  offset <= tbl_dout;
            st_attr: begin
                pal  <= tbl_dout[obj_pkg::attr_pal_hi:obj_pkg::attr_pal_lo];
                bank <= tbl_dout[obj_pkg::attr_bank_hi:obj_pkg::attr_bank_lo];
                prio <= tbl_dout[obj_pkg::attr_prio_hi:obj_pkg::attr_prio_lo];
            end
            st_scr: begin
                if (!first)
                    offset <= tbl_dout;  // carry on from scratch
            end
            st_draw: begin
                if (!dr_busy) begin
                    dr_xpos   <= xpos;
                    dr_offset <= offset;
                    dr_bank   <= bank_map;
                    dr_prio   <= prio;
                    dr_pal    <= pal;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* obj_draw.sv */
//--------------------------------------------------------------------
// sprite draw engine
// fetches graphics words for one draw command and writes the
// opaque 4-bit pixels into the line buffer, msb nibble first
//--------------------------------------------------------------------
`default_nettype none

module obj_draw (
    input  wire         clk,
    input  wire         rst,
    input  wire         dr_start,
    output logic        dr_busy,
    input  wire  [8:0]  dr_xpos,
    input  wire  [15:0] dr_offset,
    input  wire  [3:0]  dr_bank,
    input  wire  [1:0]  dr_prio,
    input  wire  [5:0]  dr_pal,
    output logic [18:0] gfx_addr,
    input  wire  [15:0] gfx_data,
    output logic        buf_we,
    output logic [8:0]  buf_addr,
    output logic [video_pkg::pxl_w-1:0] buf_pxl
);

    logic        busy;
    logic        rd_pend;     // gfx_data valid this cycle
    logic [4:0]  words_left;
    logic [2:0]  nib_left;
    logic [15:0] fetch_off;
    logic [15:0] shreg;
    logic [8:0]  x;
    logic [3:0]  bank;
    logic [1:0]  prio;
    logic [5:0]  pal;
    logic [3:0]  nib;
    logic        nib_out, nib_end, issue, all_done;

    assign nib      = shreg[15:12];
    assign nib_out  = busy && (nib_left != 3'd0);
    assign nib_end  = nib_out && (nib == obj_pkg::pix_end);
    // refill as the current word runs out
    assign issue    = busy && !rd_pend && (words_left != 5'd0)
                      && (nib_left <= 3'd1) && !nib_end;
    assign all_done = busy && !rd_pend && (words_left == 5'd0) && (nib_left == 3'd0);

    assign dr_busy  = busy;
    assign gfx_addr = {bank, fetch_off[14:0]};
    assign buf_we   = nib_out && !nib_end && (nib != obj_pkg::pix_clear);
    assign buf_addr = x;
    assign buf_pxl  = {prio, pal, nib};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            rd_pend    <= 1'b0;
            words_left <= '0;
            nib_left   <= '0;
        end else begin
            rd_pend <= issue;
            if (dr_start) begin
                busy       <= 1'b1;
                rd_pend    <= 1'b0;
                words_left <= 5'(obj_pkg::max_words);
                nib_left   <= '0;
            end else if (nib_end || all_done) begin
                busy     <= 1'b0;
                rd_pend  <= 1'b0;  // late words dropped
                nib_left <= '0;
            end else begin
                if (issue)
                    words_left <= words_left - 5'd1;
                if (rd_pend)
                    nib_left <= 3'd4;
                else if (nib_out)
                    nib_left <= nib_left - 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dr_start) begin
            x         <= dr_xpos;
            fetch_off <= dr_offset;
            bank      <= dr_bank;
            prio      <= dr_prio;
            pal       <= dr_pal;
        end else begin
            if (issue)
                fetch_off <= fetch_off + 16'd1;
            if (rd_pend) begin
                shreg <= gfx_data;
            end else if (nib_out) begin
                shreg <= {shreg[11:0], 4'h0};
                x     <= x + 9'd1;  // wraps past 511
            end
        end
    end

endmodule

`default_nettype wire

/* obj_line_buf.sv */
//--------------------------------------------------------------------
// object line buffer
// two banks swapped on hstart; one is drawn into with first
// pixel wins, the other is read out and cleared behind hdump
//--------------------------------------------------------------------
`default_nettype none

module obj_line_buf (
    input  wire         clk,
    input  wire         rst,
    input  wire         hstart,
    input  wire         buf_we,
    input  wire  [8:0]  buf_addr,
    input  wire  [video_pkg::pxl_w-1:0] buf_pxl,
    input  wire  [8:0]  hdump,
    output logic [video_pkg::pxl_w-1:0] pxl
);

    logic [video_pkg::pxl_w-1:0] mem [0:1][0:video_pkg::line_len-1];
    logic sel;          // bank being drawn
    logic taken;

    assign taken = mem[sel][buf_addr] != '0;

    always_ff @(posedge clk) begin
        if (buf_we && !taken)
            mem[sel][buf_addr] <= buf_pxl;
        mem[~sel][hdump] <= '0;  // clear behind the read
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= 1'b0;
            pxl <= '0;
        end else begin
            if (hstart)
                sel <= ~sel;
            pxl <= mem[~sel][hdump];
        end
    end

endmodule

`default_nettype wire

/* obj_top.sv */
//--------------------------------------------------------------------
// sprite subsystem top
// object table, scanner, draw engine and line buffer joined to
// the CPU write port, video timing and graphics ROM
//--------------------------------------------------------------------
`default_nettype none

module obj_top (
    input  wire         clk,
    input  wire         rst,
    input  wire  [10:1] cpu_addr,
    input  wire  [15:0] cpu_din,
    input  wire         cpu_we,
    input  wire         alt_bank,
    input  wire         flip,
    input  wire         hstart,
    input  wire  [8:0]  vrender,
    input  wire  [8:0]  hdump,
    output logic [18:0] gfx_addr,
    input  wire  [15:0] gfx_data,
    output logic [video_pkg::pxl_w-1:0] pxl
);

    // scanner to table
    logic [10:1] tbl_addr;
    logic [15:0] tbl_din;
    logic [15:0] tbl_dout;
    logic        tbl_we;

    // draw command
    logic        dr_start;
    logic        dr_busy;
    logic [8:0]  dr_xpos;
    logic [15:0] dr_offset;
    logic [3:0]  dr_bank;
    logic [1:0]  dr_prio;
    logic [5:0]  dr_pal;

    logic        buf_we;
    logic [8:0]  buf_addr;
    logic [video_pkg::pxl_w-1:0] buf_pxl;

    obj_table_ram u_table (
        .clk(clk), .cpu_addr(cpu_addr), .cpu_din(cpu_din), .cpu_we(cpu_we),
        .tbl_addr(tbl_addr), .tbl_din(tbl_din), .tbl_we(tbl_we), .tbl_dout(tbl_dout)
    );

    obj_scan u_scan (
        .clk(clk), .rst(rst), .alt_bank(alt_bank), .hstart(hstart), .flip(flip),
        .vrender(vrender), .tbl_addr(tbl_addr), .tbl_din(tbl_din), .tbl_we(tbl_we),
        .tbl_dout(tbl_dout), .dr_start(dr_start), .dr_busy(dr_busy),
        .dr_xpos(dr_xpos), .dr_offset(dr_offset), .dr_bank(dr_bank),
        .dr_prio(dr_prio), .dr_pal(dr_pal)
    );

    obj_draw u_draw (
        .clk(clk), .rst(rst), .dr_start(dr_start), .dr_busy(dr_busy),
        .dr_xpos(dr_xpos), .dr_offset(dr_offset), .dr_bank(dr_bank),
        .dr_prio(dr_prio), .dr_pal(dr_pal), .gfx_addr(gfx_addr), .gfx_data(gfx_data),
        .buf_we(buf_we), .buf_addr(buf_addr), .buf_pxl(buf_pxl)
    );

    obj_line_buf u_line_buf (
        .clk(clk), .rst(rst), .hstart(hstart), .buf_we(buf_we), .buf_addr(buf_addr),
        .buf_pxl(buf_pxl), .hdump(hdump), .pxl(pxl)
    );

endmodule

`default_nettype wire

/* obj_scan_sva.sv */
//----------------------------------------------------------------------
// scanner protocol checks
// draw handshake and scratch write rules, bound into obj_scan
//----------------------------------------------------------------------
`default_nettype none

module obj_scan_sva (
    input wire clk,
    input wire rst,
    input wire dr_start,
    input wire dr_busy,
    input wire tbl_we
);

    // no new command while the engine draws
    a_start_idle: assert property (@(posedge clk) disable iff (rst) dr_start |-> !dr_busy)
        else $error("draw start issued while the draw engine was busy");

    a_start_pulse: assert property (@(posedge clk) disable iff (rst) dr_start |=> !dr_start)
        else $error("draw start held high for more than one cycle");

    // one scratch write per visible object
    a_we_pulse: assert property (@(posedge clk) disable iff (rst) tbl_we |=> !tbl_we)
        else $error("object table written on two cycles in a row");

endmodule

bind obj_scan obj_scan_sva scan_sva0 (
    .clk(clk), .rst(rst), .dr_start(dr_start), .dr_busy(dr_busy), .tbl_we(tbl_we)
);

`default_nettype wire

/* tb_obj_top.sv */
//----------------------------------------------------------------------
// sprite subsystem testbench
// loads a sprite table over the CPU port, renders a list of lines
// and compares the line buffer output with a reference model
//----------------------------------------------------------------------
`default_nettype none

module tb_obj_top;

    localparam int n_spr      = 9;
    localparam int n_lines    = 11;
    localparam int line_gap   = 3000;
    localparam int max_cycles = (n_lines + 3) * 3600;  // two blank lines plus load time

    typedef struct packed {
        logic [15:0] pos;     // bottom, top
        logic [8:0]  xpos;
        logic [15:0] pitch;
        logic [15:0] offset;
        logic [15:0] attr;    // pal 13:8, bank 6:4, prio 1:0
    } spr_t;

    logic        clk;
    logic        rst;
    logic [10:1] cpu_addr;
    logic [15:0] cpu_din;
    logic        cpu_we, alt_bank, flip, hstart;
    logic [8:0]  vrender, hdump;
    logic [18:0] gfx_addr;
    logic [15:0] gfx_data = '0;
    logic [11:0] pxl;

    spr_t        spr_tab [0:n_spr-1];
    logic [10:0] line_tab [0:n_lines-1];   // flip, alt_bank, vrender
    logic [15:0] rom_pat [0:7];
    logic [15:0] scratch [0:n_spr-1];      // model of the running offsets
    logic [11:0] exp_line [0:video_pkg::line_len-1];
    logic [18:0] exp_gfx;                  // rom address left by the last sprite
    logic        gfx_seen;                 // some sprite drawn on this line
    int          errors, checks;
    int          cycles = 0;

    obj_top dut0 (
        .clk(clk), .rst(rst), .cpu_addr(cpu_addr), .cpu_din(cpu_din), .cpu_we(cpu_we),
        .alt_bank(alt_bank), .flip(flip), .hstart(hstart), .vrender(vrender),
        .hdump(hdump), .gfx_addr(gfx_addr), .gfx_data(gfx_data), .pxl(pxl)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [3:0] bank_nib(input logic [3:0] b);
        return (b == 4'hf) ? 4'he : b + 4'h1;
    endfunction

    // low region from the pattern table, offsets with bit 12 set never end
    function automatic logic [15:0] rom_word(input logic [18:0] a);
        logic [3:0] bn;
        bn = bank_nib(a[18:15]);
        if (a[12])
            return {bn, 4'h0, {1'b0, a[2:0]} + 4'h1, bn};
        return rom_pat[a[2:0]];
    endfunction

    always @(posedge clk)
        gfx_data <= rom_word(gfx_addr);  // one cycle read latency

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run still going after %0d cycles", max_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [3:0] map_bank(input logic [2:0] b, input logic alt);
        if (!alt)
            return {1'b0, b};
        case ({1'b0, b})
            4'd0:    return 4'd0;
            4'd7:    return 4'd3;
            4'd11:   return 4'd2;
            4'd13:   return 4'd1;
            4'd14:   return 4'd0;
            default: return 4'd15;
        endcase
    endfunction

    task automatic check_val(input logic [31:0] got, input logic [31:0] want,
                             input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic fill_tables();
        rom_pat[0] = 16'h1234;
        rom_pat[1] = 16'h5067;
        rom_pat[2] = 16'h809a;
        rom_pat[3] = 16'hbc0d;
        rom_pat[4] = 16'he1f2;   // ends after two pixels
        rom_pat[5] = 16'h3400;
        rom_pat[6] = 16'h0506;
        rom_pat[7] = 16'h7f00;
        //            pos       xpos     pitch     offset    attr
        spr_tab[0] = {16'h140a, 9'd20,  16'h0002, 16'h0000, 16'h0512};
        spr_tab[1] = {16'h1e0a, 9'd22,  16'h0000, 16'h1000, 16'h0921};  // full 16 words
        spr_tab[2] = {16'h0c0f, 9'd100, 16'h0000, 16'h0000, 16'h0110};  // top above bottom
        spr_tab[3] = {16'h3228, 9'd200, 16'hfffd, 16'h0005, 16'h0333};  // negative pitch
        spr_tab[4] = {16'h6e64, 9'd505, 16'h0001, 16'h1003, 16'h2170};  // wraps past 511
        spr_tab[5] = {16'h6e64, 9'd300, 16'h0000, 16'h1002, 16'h3f51};
        spr_tab[6] = {16'hd2c8, 9'd64,  16'h0000, 16'h0004, 16'h0702};
        spr_tab[7] = {16'hf000, 9'd0,   16'h0000, 16'h0000, 16'h0000};  // end of table
        spr_tab[8] = {16'hef00, 9'd400, 16'h0000, 16'h1000, 16'h0a40};
        line_tab[0]  = {1'b0, 1'b0, 9'd10};
        line_tab[1]  = {1'b0, 1'b0, 9'd11};
        line_tab[2]  = {1'b0, 1'b0, 9'd12};
        line_tab[3]  = {1'b0, 1'b0, 9'd40};
        line_tab[4]  = {1'b0, 1'b0, 9'd41};
        line_tab[5]  = {1'b0, 1'b0, 9'd42};
        line_tab[6]  = {1'b0, 1'b0, 9'd100};
        line_tab[7]  = {1'b0, 1'b1, 9'd100};
        line_tab[8]  = {1'b1, 1'b0, 9'd23};   // flipped line 200
        line_tab[9]  = {1'b0, 1'b0, 9'd23};
        line_tab[10] = {1'b0, 1'b0, 9'd15};
    endtask

    task automatic write_word(input int obj, input logic [2:0] word, input logic [15:0] d);
        @(posedge clk);
        cpu_addr <= {7'(obj), word};
        cpu_din  <= d;
        cpu_we   <= 1'b1;
    endtask

    task automatic load_table();
        for (int o = 0; o < n_spr; o++) begin
            write_word(o, obj_pkg::word_pos, spr_tab[o].pos);
            write_word(o, obj_pkg::word_xpos, {7'd0, spr_tab[o].xpos});
            write_word(o, obj_pkg::word_pitch, spr_tab[o].pitch);
            write_word(o, obj_pkg::word_offset, spr_tab[o].offset);
            write_word(o, obj_pkg::word_attr, spr_tab[o].attr);
            write_word(o, obj_pkg::word_scratch, spr_tab[o].offset);
            scratch[o] = spr_tab[o].offset;
        end
        @(posedge clk);
        cpu_we <= 1'b0;
    endtask

    // expected line from the zone, offset, pixel and priority rules
    task automatic build_expected(input logic [8:0] vr, input logic fl, input logic alt);
        logic [8:0]  vl;
        logic [7:0]  top, bottom;
        logic [15:0] base, w;
        logic [3:0]  bank, n;
        logic [8:0]  x;
        logic        done;
        int          nw;
        spr_t        s;
        gfx_seen = 1'b0;
        for (int i = 0; i < video_pkg::line_len; i++)
            exp_line[i] = '0;
        vl = fl ? video_pkg::flip_base - vr : vr;
        if (vl >= 9'(video_pkg::vis_lines))
            return;
        for (int o = 0; o < n_spr; o++) begin
            s      = spr_tab[o];
            top    = s.pos[7:0];
            bottom = s.pos[15:8];
            if (bottom >= obj_pkg::eot_bottom)
                break;
            if (top < bottom && top <= vl[7:0] && vl[7:0] < bottom) begin
                base       = (vl[7:0] == top) ? s.offset : scratch[o];
                scratch[o] = base + s.pitch;
                bank       = map_bank(s.attr[6:4], alt);
                x          = s.xpos;
                done       = 1'b0;
                nw         = 0;
                for (int k = 0; k < obj_pkg::max_words && !done; k++) begin
                    w  = rom_word({bank, 15'(base + 16'(k))});
                    nw = k + 1;
                    for (int j = 3; j >= 0 && !done; j--) begin
                        n = w[4*j +: 4];
                        if (n == obj_pkg::pix_end) begin
                            done = 1'b1;
                        end else begin
                            if (n != obj_pkg::pix_clear && exp_line[x] == '0)
                                exp_line[x] = {s.attr[1:0], s.attr[13:8], n};
                            x = x + 9'd1;
                        end
                    end
                end
                // address counter stops one past the last word fetched
                exp_gfx  = {bank, 15'(base + 16'(nw))};
                gfx_seen = 1'b1;
            end
        end
    endtask

    task automatic pulse_hstart();
        @(posedge clk);
        hstart <= 1'b1;
        @(posedge clk);
        hstart <= 1'b0;
    endtask

    // hdump sits at 0 through the swap, pxl trails hdump by one cycle
    task automatic read_line(input bit compare, input int line_no);
        for (int k = 1; k <= video_pkg::line_len; k++) begin
            @(posedge clk);
            if (k < video_pkg::line_len)
                hdump <= 9'(k);
            @(negedge clk);
            if (compare)
                check_val(32'(pxl), 32'(exp_line[k-1]),
                          $sformatf("line %0d position %0d", line_no, k - 1));
        end
        @(posedge clk);
        hdump <= '0;
    endtask

    task automatic run_line(input int i);
        logic [8:0] vr;
        vr = line_tab[i][8:0];
        build_expected(vr, line_tab[i][10], line_tab[i][9]);
        @(posedge clk);
        vrender  <= vr;
        flip     <= line_tab[i][10];
        alt_bank <= line_tab[i][9];
        pulse_hstart();
        repeat (line_gap) @(posedge clk);
        vrender <= 9'd300;  // blank line, the swap starts no scan
        @(negedge clk);
        if (gfx_seen)
            check_val(32'(gfx_addr), 32'(exp_gfx), $sformatf("line %0d gfx_addr", i));
        pulse_hstart();
        read_line(1'b1, i);
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        rst      = 1'b1;
        cpu_addr = '0;
        cpu_din  = '0;
        cpu_we   = 1'b0;
        alt_bank = 1'b0;
        flip     = 1'b0;
        hstart   = 1'b0;
        vrender  = 9'd300;
        hdump    = '0;
        fill_tables();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        load_table();
        // sweep both banks once so they start out clear
        pulse_hstart();
        read_line(1'b0, 0);
        pulse_hstart();
        read_line(1'b0, 0);
        for (int i = 0; i < n_lines; i++)
            run_line(i);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
video_pkg.sv
obj_pkg.sv
obj_table_ram.sv
obj_scan.sv
obj_draw.sv
obj_line_buf.sv
obj_top.sv
obj_scan_sva.sv
tb_obj_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_obj_top
FLIST     := compile.f
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall -Wno-fatal
LOG       := sim.log
SIM       := obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG) || ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
